/* rtl/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    // basic widths
    localparam int word_w = 32;
    localparam int addr_w = 32;
    localparam int inst_w = 64;

    // data word: store data, read data, load result
    typedef logic [word_w-1:0] word_t;

    // byte address
    typedef logic [addr_w-1:0] addr_t;

    // one-hot decoded instruction, one bit per instruction
    typedef logic [inst_w-1:0] inst_vec_t;

    // bit positions of the memory instructions in inst_vec_t
    localparam int inst_lb  = 10;
    localparam int inst_lh  = 11;
    localparam int inst_lw  = 12;
    localparam int inst_lbu = 13;
    localparam int inst_lhu = 14;
    localparam int inst_sb  = 15;
    localparam int inst_sh  = 16;
    localparam int inst_sw  = 17;

    // access size, code 3 unused
    typedef logic [1:0] size_t;

    localparam size_t size_byte = 2'd0;
    localparam size_t size_half = 2'd1;
    localparam size_t size_word = 2'd2;

    // byte lane write mask, bit n enables bits 8n+7..8n
    typedef logic [3:0] lane_t;

endpackage

`default_nettype wire

/* rtl/mem_req_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_req_stage (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               op_valid,
    input  wire lsu_pkg::inst_vec_t inst,
    input  wire lsu_pkg::word_t     base,
    input  wire lsu_pkg::word_t     offset,
    input  wire lsu_pkg::word_t     store_data,
    output logic                    req_valid,
    output logic                    req_load,
    output logic                    req_store,
    output logic                    req_signed,
    output logic                    req_fault,
    output lsu_pkg::size_t          req_size,
    output lsu_pkg::addr_t          req_addr,
    output lsu_pkg::word_t          req_wdata
);

    // decoded fields of the incoming operation
    logic           is_load;
    logic           is_store;
    logic           is_signed;
    lsu_pkg::size_t size;
    lsu_pkg::addr_t addr;
    logic           misaligned;

    // effective address, wraps modulo 2^32
    assign addr = base + offset;

    // exact one-hot match, anything else is a no-op
    always_comb begin
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_signed = 1'b0;
        size      = lsu_pkg::size_word;
        case (inst)
            (lsu_pkg::inst_vec_t'(1) << lsu_pkg::inst_lb): begin
                is_load   = 1'b1;
                is_signed = 1'b1;
                size      = lsu_pkg::size_byte;
            end
            (lsu_pkg::inst_vec_t'(1) << lsu_pkg::inst_lh): begin
                is_load   = 1'b1;
                is_signed = 1'b1;
                size      = lsu_pkg::size_half;
            end
            (lsu_pkg::inst_vec_t'(1) << lsu_pkg::inst_lw): begin
                is_load = 1'b1;
            end
            (lsu_pkg::inst_vec_t'(1) << lsu_pkg::inst_lbu): begin
                is_load = 1'b1;
                size    = lsu_pkg::size_byte;
            end
            (lsu_pkg::inst_vec_t'(1) << lsu_pkg::inst_lhu): begin
                is_load = 1'b1;
                size    = lsu_pkg::size_half;
            end
            (lsu_pkg::inst_vec_t'(1) << lsu_pkg::inst_sb): begin
                is_store = 1'b1;
                size     = lsu_pkg::size_byte;
            end
            (lsu_pkg::inst_vec_t'(1) << lsu_pkg::inst_sh): begin
                is_store = 1'b1;
                size     = lsu_pkg::size_half;
            end
            (lsu_pkg::inst_vec_t'(1) << lsu_pkg::inst_sw): begin
                is_store = 1'b1;
            end
            default: begin
                // non-memory bit or several bits set, defaults hold
            end
        endcase
    end

    // halves need even address, words need a multiple of four
    always_comb begin
        case (size)
            lsu_pkg::size_half: misaligned = addr[0];
            lsu_pkg::size_word: misaligned = (addr[1:0] != 2'b00);
            default:            misaligned = 1'b0;
        endcase
    end

    // control bits, valid marks a real memory op
    always_ff @(posedge clk) begin
        if (reset) begin
            req_valid <= 1'b0;
            req_load  <= 1'b0;
            req_store <= 1'b0;
            req_fault <= 1'b0;
        end else begin
            req_valid <= op_valid && (is_load || is_store);
            // faulting ops are neither load nor store
            req_load  <= is_load && !misaligned;
            req_store <= is_store && !misaligned;
            req_fault <= (is_load || is_store) && misaligned;
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        req_size   <= size;
        req_signed <= is_signed;
        req_addr   <= addr;
        req_wdata  <= store_data;
    end

endmodule

`default_nettype wire

/* rtl/data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module data_mem #(
    parameter int mem_words = 1024
) (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           req_valid,
    input  wire logic           req_load,
    input  wire logic           req_store,
    input  wire logic           req_signed,
    input  wire logic           req_fault,
    input  wire lsu_pkg::size_t req_size,
    input  wire lsu_pkg::addr_t req_addr,
    input  wire lsu_pkg::word_t req_wdata,
    output logic                rd_valid,
    output logic                rd_signed,
    output logic                store_done,
    output logic                fault_out,
    output lsu_pkg::size_t      rd_size,
    output logic [1:0]          rd_offset,
    output lsu_pkg::word_t      rd_word
);

    // word index width, mem_words is a power of two
    localparam int idx_w = $clog2(mem_words);

    lsu_pkg::word_t mem [mem_words];

    // lane mask and replicated store data for the request
    lsu_pkg::lane_t lane;
    lsu_pkg::word_t wdata_rep;

    // address phase registers
    logic             st_en_q;
    logic             ld_en_q;
    logic             flt_q;
    logic [idx_w-1:0] idx_q;
    lsu_pkg::lane_t   lane_q;
    lsu_pkg::word_t   wdata_q;
    lsu_pkg::size_t   size_q;
    logic             signed_q;
    logic [1:0]       offset_q;

    // byte lanes touched by the access
    always_comb begin
        case (req_size)
            lsu_pkg::size_byte: begin
                lane      = lsu_pkg::lane_t'(4'b0001 << req_addr[1:0]);
                wdata_rep = {4{req_wdata[7:0]}};
            end
            lsu_pkg::size_half: begin
                lane      = lsu_pkg::lane_t'(4'b0011 << {req_addr[1], 1'b0});
                wdata_rep = {2{req_wdata[15:0]}};
            end
            default: begin
                lane      = 4'b1111;
                wdata_rep = req_wdata;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            st_en_q <= 1'b0;
            ld_en_q <= 1'b0;
            flt_q   <= 1'b0;
        end else begin
            st_en_q <= req_valid && req_store;
            ld_en_q <= req_valid && req_load;
            flt_q   <= req_valid && req_fault;
        end
    end

    // word index wraps modulo mem_words
    always_ff @(posedge clk) begin
        idx_q    <= req_addr[idx_w+1:2];
        lane_q   <= lane;
        wdata_q  <= wdata_rep;
        size_q   <= req_size;
        signed_q <= req_signed;
        offset_q <= req_addr[1:0];
    end

    // one-cycle clear, then masked byte writes
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < mem_words; i++) begin
                mem[i] <= '0;
            end
        end else if (st_en_q) begin
            for (int b = 0; b < 4; b++) begin
                if (lane_q[b]) begin
                    mem[idx_q][8*b +: 8] <= wdata_q[8*b +: 8];
                end
            end
        end
    end

    // result pulses of this stage
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid   <= 1'b0;
            store_done <= 1'b0;
            fault_out  <= 1'b0;
        end else begin
            rd_valid   <= ld_en_q;
            store_done <= st_en_q;
            fault_out  <= flt_q;
        end
    end

    // full word read, sees writes from earlier edges
    always_ff @(posedge clk) begin
        rd_word   <= mem[idx_q];
        rd_size   <= size_q;
        rd_signed <= signed_q;
        rd_offset <= offset_q;
    end

endmodule

`default_nettype wire

/* rtl/load_align.sv */
`timescale 1ns/1ps
`default_nettype none

module load_align (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           rd_valid,
    input  wire logic           rd_signed,
    input  wire lsu_pkg::size_t rd_size,
    input  wire logic [1:0]     rd_offset,
    input  wire lsu_pkg::word_t rd_word,
    input  wire logic           store_done,
    input  wire logic           fault_out,
    output logic                load_valid,
    output logic                store_done_q,
    output logic                fault_q,
    output lsu_pkg::word_t      load_data
);

    // addressed byte or half moved down to bit 0
    lsu_pkg::word_t shifted;
    lsu_pkg::word_t extended;

    assign shifted = rd_word >> {rd_offset, 3'b000};

    // sign or zero extension by size
    always_comb begin
        case (rd_size)
            lsu_pkg::size_byte:
                extended = {{24{rd_signed & shifted[7]}}, shifted[7:0]};
            lsu_pkg::size_half:
                extended = {{16{rd_signed & shifted[15]}}, shifted[15:0]};
            default:
                extended = shifted;
        endcase
    end

    // all three pulses leave on the same edge
    always_ff @(posedge clk) begin
        if (reset) begin
            load_valid   <= 1'b0;
            store_done_q <= 1'b0;
            fault_q      <= 1'b0;
        end else begin
            load_valid   <= rd_valid;
            store_done_q <= store_done;
            fault_q      <= fault_out;
        end
    end

    always_ff @(posedge clk) begin
        load_data <= extended;
    end

endmodule

`default_nettype wire

/* rtl/lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
    parameter int mem_words = 1024
) (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               op_valid,
    input  wire lsu_pkg::inst_vec_t inst,
    input  wire lsu_pkg::word_t     base,
    input  wire lsu_pkg::word_t     offset,
    input  wire lsu_pkg::word_t     store_data,
    output logic                    load_valid,
    output lsu_pkg::word_t          load_data,
    output logic                    store_done,
    output logic                    fault
);

    // request stage to memory
    logic           req_valid;
    logic           req_load;
    logic           req_store;
    logic           req_signed;
    logic           req_fault;
    lsu_pkg::size_t req_size;
    lsu_pkg::addr_t req_addr;
    lsu_pkg::word_t req_wdata;

    // memory to load alignment
    logic           rd_valid;
    logic           rd_signed;
    logic           mem_store_done;
    logic           mem_fault;
    lsu_pkg::size_t rd_size;
    logic [1:0]     rd_offset;
    lsu_pkg::word_t rd_word;

    // stage 1, decode and address
    mem_req_stage mem_req_stage_i (
        .clk        (clk),
        .reset      (reset),
        .op_valid   (op_valid),
        .inst       (inst),
        .base       (base),
        .offset     (offset),
        .store_data (store_data),
        .req_valid  (req_valid),
        .req_load   (req_load),
        .req_store  (req_store),
        .req_signed (req_signed),
        .req_fault  (req_fault),
        .req_size   (req_size),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata)
    );

    // stage 2, memory array
    data_mem #(
        .mem_words (mem_words)
    ) data_mem_i (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_load   (req_load),
        .req_store  (req_store),
        .req_signed (req_signed),
        .req_fault  (req_fault),
        .req_size   (req_size),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .rd_valid   (rd_valid),
        .rd_signed  (rd_signed),
        .store_done (mem_store_done),
        .fault_out  (mem_fault),
        .rd_size    (rd_size),
        .rd_offset  (rd_offset),
        .rd_word    (rd_word)
    );

    // stage 3, extract and extend
    load_align load_align_i (
        .clk          (clk),
        .reset        (reset),
        .rd_valid     (rd_valid),
        .rd_signed    (rd_signed),
        .rd_size      (rd_size),
        .rd_offset    (rd_offset),
        .rd_word      (rd_word),
        .store_done   (mem_store_done),
        .fault_out    (mem_fault),
        .load_valid   (load_valid),
        .store_done_q (store_done),
        .fault_q      (fault),
        .load_data    (load_data)
    );

endmodule

`default_nettype wire

/* verification/lsu_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_checker (
    input wire logic               clk,
    input wire logic               reset,
    input wire logic               op_valid,
    input wire lsu_pkg::inst_vec_t inst,
    input wire logic               load_valid,
    input wire logic               store_done,
    input wire logic               fault
);

    // failed assertions, summed by the testbench at the end of the run
    int unsigned assert_fails = 0;

    // reset as seen one and two edges back
    logic rst_d1 = 1'b0;
    logic rst_d2 = 1'b0;

    // exactly one bit set, and it is one of the eight memory instructions
    logic mem_op;

    assign mem_op = $onehot(inst) && (inst[lsu_pkg::inst_sw:lsu_pkg::inst_lb] != '0);

    always @(posedge clk) begin
        rst_d1 <= reset;
        rst_d2 <= rst_d1;
    end

    // at most one result per cycle
    pulses_exclusive: assert property (@(posedge clk) disable iff (reset)
        $onehot0({load_valid, store_done, fault}))
    else begin
        assert_fails++;
        $error("load_valid, store_done and fault high together");
    end

    // pulse is registered at k+3, so it is sampled at the edge after
    one_result_per_op: assert property (@(posedge clk) disable iff (reset)
        (op_valid && mem_op) |-> ##4 $onehot({load_valid, store_done, fault}))
    else begin
        assert_fails++;
        $error("memory op not followed by exactly one result pulse");
    end

    // stage registers are cleared, nothing can leave yet
    quiet_after_reset: assert property (@(posedge clk)
        (rst_d1 || rst_d2) |-> !(load_valid || store_done || fault))
    else begin
        assert_fails++;
        $error("result pulse during reset or in the cycle after");
    end

endmodule

`default_nettype wire

/* verification/lsu_scoreboard.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_scoreboard (
    input  wire logic           clk,
    input  wire logic           reset,
    // expectation for the op driven into the DUT this cycle
    input  wire logic           issue,
    input  var  int             issue_id,
    input  wire logic [2:0]     exp_pulse,
    input  wire lsu_pkg::word_t exp_data,
    // DUT results
    input  wire logic           load_valid,
    input  wire lsu_pkg::word_t load_data,
    input  wire logic           store_done,
    input  wire logic           fault,
    output int                  pass_count,
    output int                  fail_count,
    output int                  checked
);

    // ops in flight, slot 3 is due at this edge
    logic           pipe_v    [4];
    int             pipe_id   [4];
    logic [2:0]     pipe_exp  [4];
    lsu_pkg::word_t pipe_data [4];

    // pulse vector order is {load_valid, store_done, fault}
    function automatic string pulse_name(logic [2:0] p);
        case (p)
            3'b000:  return "no pulse";
            3'b100:  return "load_valid";
            3'b010:  return "store_done";
            3'b001:  return "fault";
            default: return "several pulses";
        endcase
    endfunction

    task automatic check_result(int id, logic [2:0] exp, lsu_pkg::word_t exp_d,
                                logic [2:0] got, lsu_pkg::word_t got_d);
        checked++;
        if (got !== exp) begin
            $display("test %0d: expected %s, got %s", id, pulse_name(exp), pulse_name(got));
            fail_count++;
        end else if (exp[2] && (got_d !== exp_d)) begin
            $display("MISMATCH load_data test %0d: expected %08h, got %08h", id, exp_d, got_d);
            fail_count++;
        end else if (exp[2]) begin
            $display("test %0d: ok, load_data %08h", id, got_d);
            pass_count++;
        end else begin
            $display("test %0d: ok, %s", id, pulse_name(got));
            pass_count++;
        end
    endtask

    // outputs read here are the values registered at the previous edge
    always @(posedge clk) begin
        logic [2:0] got;
        got = {load_valid, store_done, fault};
        if (reset) begin
            pass_count = 0;
            fail_count = 0;
            checked    = 0;
            for (int i = 0; i < 4; i++) begin
                pipe_v[i] = 1'b0;
            end
        end else begin
            if (pipe_v[3]) begin
                check_result(pipe_id[3], pipe_exp[3], pipe_data[3], got, load_data);
            end else if (got !== 3'b000) begin
                $display("unexpected %s with no operation in flight", pulse_name(got));
                fail_count++;
            end
            for (int i = 3; i > 0; i--) begin
                pipe_v[i]    = pipe_v[i-1];
                pipe_id[i]   = pipe_id[i-1];
                pipe_exp[i]  = pipe_exp[i-1];
                pipe_data[i] = pipe_data[i-1];
            end
            pipe_v[0]    = issue;
            pipe_id[0]   = issue_id;
            pipe_exp[0]  = exp_pulse;
            pipe_data[0] = exp_data;
        end
    end

endmodule

`default_nettype wire

/* verification/tb_lsu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lsu;

    localparam int mem_words = 1024;

    // one row of the stimulus table, exp_pulse is {load, store, fault}
    typedef struct {
        logic               valid;
        lsu_pkg::inst_vec_t inst;
        lsu_pkg::word_t     base;
        lsu_pkg::word_t     offset;
        lsu_pkg::word_t     data;
        logic [2:0]         exp_pulse;
        lsu_pkg::word_t     exp_data;
    } op_entry_t;

    logic               clk = 1'b0;
    logic               reset;
    logic               op_valid;
    lsu_pkg::inst_vec_t inst;
    lsu_pkg::word_t     base;
    lsu_pkg::word_t     offset;
    lsu_pkg::word_t     store_data;
    logic               load_valid;
    lsu_pkg::word_t     load_data;
    logic               store_done;
    logic               fault;

    // expectation handed to the scoreboard
    logic               issue;
    int                 issue_id;
    logic [2:0]         exp_pulse;
    lsu_pkg::word_t     exp_data;
    int                 pass_count;
    int                 fail_count;
    int                 checked;

    op_entry_t          op_table [$];
    lsu_pkg::word_t     model [int unsigned];
    logic [31:0]        rng_state = 32'hc801;
    int                 cycles = 0;
    int unsigned        assert_total;

    always #50 clk = ~clk;

    lsu_top #(
        .mem_words (mem_words)
    ) lsu_top_i (
        .clk        (clk),
        .reset      (reset),
        .op_valid   (op_valid),
        .inst       (inst),
        .base       (base),
        .offset     (offset),
        .store_data (store_data),
        .load_valid (load_valid),
        .load_data  (load_data),
        .store_done (store_done),
        .fault      (fault)
    );

    lsu_scoreboard lsu_scoreboard_i (
        .clk        (clk),
        .reset      (reset),
        .issue      (issue),
        .issue_id   (issue_id),
        .exp_pulse  (exp_pulse),
        .exp_data   (exp_data),
        .load_valid (load_valid),
        .load_data  (load_data),
        .store_done (store_done),
        .fault      (fault),
        .pass_count (pass_count),
        .fail_count (fail_count),
        .checked    (checked)
    );

    bind lsu_top lsu_checker lsu_checker_i (
        .clk        (clk),
        .reset      (reset),
        .op_valid   (op_valid),
        .inst       (inst),
        .load_valid (load_valid),
        .store_done (store_done),
        .fault      (fault)
    );

    function automatic lsu_pkg::word_t next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic lsu_pkg::inst_vec_t one_hot(int pos);
        return lsu_pkg::inst_vec_t'(1) << pos;
    endfunction

    // untouched words read as zero
    function automatic lsu_pkg::word_t read_model(int unsigned idx);
        if (model.exists(idx)) begin
            return model[idx];
        end
        return '0;
    endfunction

    // appends one op and works out its result from the memory model
    task automatic add_op(lsu_pkg::inst_vec_t op_inst, lsu_pkg::word_t op_base,
                          lsu_pkg::word_t op_offset, lsu_pkg::word_t op_data);
        op_entry_t      e;
        lsu_pkg::addr_t addr;
        lsu_pkg::word_t w;
        int unsigned    idx;
        int             pos;
        int             nbytes;
        int             lane;
        logic           is_store;
        logic           is_signed;
        e.valid     = 1'b1;
        e.inst      = op_inst;
        e.base      = op_base;
        e.offset    = op_offset;
        e.data      = op_data;
        e.exp_pulse = 3'b000;
        e.exp_data  = '0;
        addr = op_base + op_offset;
        idx  = (addr >> 2) % mem_words;
        pos  = -1;
        if ($countones(op_inst) == 1) begin
            for (int i = 0; i < 64; i++) begin
                if (op_inst[i]) begin
                    pos = i;
                end
            end
        end
        case (pos)
            lsu_pkg::inst_lb, lsu_pkg::inst_lbu, lsu_pkg::inst_sb: nbytes = 1;
            lsu_pkg::inst_lh, lsu_pkg::inst_lhu, lsu_pkg::inst_sh: nbytes = 2;
            lsu_pkg::inst_lw, lsu_pkg::inst_sw:                    nbytes = 4;
            default:                                               nbytes = 0;
        endcase
        is_store  = (pos == lsu_pkg::inst_sb) || (pos == lsu_pkg::inst_sh) ||
                    (pos == lsu_pkg::inst_sw);
        is_signed = (pos == lsu_pkg::inst_lb) || (pos == lsu_pkg::inst_lh);
        if (nbytes == 0) begin
            // no-op, nothing comes back
        end else if ((addr % nbytes) != 0) begin
            e.exp_pulse = 3'b001;
        end else if (is_store) begin
            e.exp_pulse = 3'b010;
            w = read_model(idx);
            for (int i = 0; i < nbytes; i++) begin
                lane = addr[1:0] + i;
                w[8*lane +: 8] = op_data[8*i +: 8];
            end
            model[idx] = w;
        end else begin
            e.exp_pulse = 3'b100;
            w = read_model(idx) >> (8 * addr[1:0]);
            for (int i = 0; i < 4; i++) begin
                if (i < nbytes) begin
                    e.exp_data[8*i +: 8] = w[8*i +: 8];
                end else begin
                    e.exp_data[8*i +: 8] = (is_signed && w[8*nbytes-1]) ? 8'hff : 8'h00;
                end
            end
        end
        op_table.push_back(e);
    endtask

    // memory instruction on the inputs with the strobe low, ignored
    task automatic add_unstrobed_op(lsu_pkg::inst_vec_t op_inst, lsu_pkg::word_t op_base,
                                    lsu_pkg::word_t op_offset, lsu_pkg::word_t op_data);
        op_entry_t e;
        e.valid     = 1'b0;
        e.inst      = op_inst;
        e.base      = op_base;
        e.offset    = op_offset;
        e.data      = op_data;
        e.exp_pulse = 3'b000;
        e.exp_data  = '0;
        op_table.push_back(e);
    endtask

    task automatic build_table();
        lsu_pkg::word_t b;
        // fresh memory reads zero
        add_op(one_hot(lsu_pkg::inst_lw), 32'h0000_0000, 32'h0, 32'h0);
        add_op(one_hot(lsu_pkg::inst_lw), 32'h0000_0040, 32'h0, 32'h0);
        add_op(one_hot(lsu_pkg::inst_lw), 32'h0000_0ff0, 32'h0000_000c, 32'h0);
        add_op(one_hot(lsu_pkg::inst_lbu), 32'h0000_0123, 32'h0, 32'h0);
        // store then load back to back, one with a negative offset
        add_op(one_hot(lsu_pkg::inst_sw), 32'h0000_0100, 32'h0, 32'h1234_5678);
        add_op(one_hot(lsu_pkg::inst_lw), 32'h0000_0100, 32'h0, 32'h0);
        add_op(one_hot(lsu_pkg::inst_sw), 32'h0000_0208, 32'hffff_fff8, next_random());
        add_op(one_hot(lsu_pkg::inst_lw), 32'h0000_0200, 32'h0, 32'h0);
        // random word addresses
        for (int i = 0; i < 4; i++) begin
            b = next_random() & 32'h0000_0ffc;
            add_op(one_hot(lsu_pkg::inst_sw), b, 32'h0, next_random());
            add_op(one_hot(lsu_pkg::inst_lw), b, 32'h0, 32'h0);
        end
        // each byte lane, then both halves, of a known word
        add_op(one_hot(lsu_pkg::inst_sw), 32'h0000_0300, 32'h0, next_random());
        for (int i = 0; i < 4; i++) begin
            add_op(one_hot(lsu_pkg::inst_sb), 32'h0000_0300, i, next_random());
            add_op(one_hot(lsu_pkg::inst_lw), 32'h0000_0300, 32'h0, 32'h0);
        end
        add_op(one_hot(lsu_pkg::inst_sw), 32'h0000_0310, 32'h0, next_random());
        for (int i = 0; i < 4; i += 2) begin
            add_op(one_hot(lsu_pkg::inst_sh), 32'h0000_0310, i, next_random());
            add_op(one_hot(lsu_pkg::inst_lw), 32'h0000_0310, 32'h0, 32'h0);
        end
        // bytes fe 7f 01 80, halves 7ffe 8001
        add_op(one_hot(lsu_pkg::inst_sw), 32'h0000_0400, 32'h0, 32'h8001_7ffe);
        for (int i = 0; i < 4; i++) begin
            add_op(one_hot(lsu_pkg::inst_lb), 32'h0000_0400, i, 32'h0);
            add_op(one_hot(lsu_pkg::inst_lbu), 32'h0000_0400, i, 32'h0);
        end
        for (int i = 0; i < 4; i += 2) begin
            add_op(one_hot(lsu_pkg::inst_lh), 32'h0000_0400, i, 32'h0);
            add_op(one_hot(lsu_pkg::inst_lhu), 32'h0000_0400, i, 32'h0);
        end
        // misaligned accesses fault and leave memory alone
        add_op(one_hot(lsu_pkg::inst_sw), 32'h0000_0500, 32'h0, 32'hcafe_f00d);
        add_op(one_hot(lsu_pkg::inst_lh), 32'h0000_0500, 32'h1, 32'h0);
        add_op(one_hot(lsu_pkg::inst_lhu), 32'h0000_0500, 32'h3, 32'h0);
        add_op(one_hot(lsu_pkg::inst_sh), 32'h0000_0500, 32'h1, 32'hffff_ffff);
        add_op(one_hot(lsu_pkg::inst_lw), 32'h0000_0500, 32'h2, 32'h0);
        add_op(one_hot(lsu_pkg::inst_sw), 32'h0000_0500, 32'h3, 32'hffff_ffff);
        add_op(one_hot(lsu_pkg::inst_sw), 32'h0000_0501, 32'h0, 32'h0);
        add_op(one_hot(lsu_pkg::inst_lw), 32'h0000_0500, 32'h0, 32'h0);
        // no-ops, a non-memory bit, two bits set, and a store with no strobe
        add_op(one_hot(18), 32'h0000_0500, 32'h0, 32'h0);
        add_op(one_hot(lsu_pkg::inst_lw) | one_hot(lsu_pkg::inst_sw), 32'h0000_0500, 32'h0,
               32'h0);
        add_op(one_hot(lsu_pkg::inst_lb) | one_hot(lsu_pkg::inst_lh), 32'h0000_0500, 32'h0,
               32'h0);
        add_unstrobed_op(one_hot(lsu_pkg::inst_sw), 32'h0000_0500, 32'h0, 32'hffff_ffff);
        add_op(one_hot(lsu_pkg::inst_lw), 32'h0000_0500, 32'h0, 32'h0);
        // word index and address both wrap
        add_op(one_hot(lsu_pkg::inst_sw), 32'h0000_0020 + mem_words * 4, 32'h0, next_random());
        add_op(one_hot(lsu_pkg::inst_lw), 32'h0000_0020, 32'h0, 32'h0);
        add_op(one_hot(lsu_pkg::inst_lw), 32'h1000_0020, 32'h0, 32'h0);
        add_op(one_hot(lsu_pkg::inst_lw), 32'hffff_fff0, 32'h0000_0030, 32'h0);
    endtask

    initial begin
        reset      = 1'b1;
        op_valid   = 1'b0;
        inst       = '0;
        base       = '0;
        offset     = '0;
        store_data = '0;
        issue      = 1'b0;
        issue_id   = 0;
        exp_pulse  = 3'b000;
        exp_data   = '0;
        build_table();
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // one op per cycle, driven away from the rising edge
        for (int i = 0; i < op_table.size(); i++) begin
            op_valid   = op_table[i].valid;
            inst       = op_table[i].inst;
            base       = op_table[i].base;
            offset     = op_table[i].offset;
            store_data = op_table[i].data;
            issue      = 1'b1;
            issue_id   = i;
            exp_pulse  = op_table[i].exp_pulse;
            exp_data   = op_table[i].exp_data;
            @(negedge clk);
        end
        op_valid = 1'b0;
        inst     = '0;
        issue    = 1'b0;
        while (checked < op_table.size()) begin
            @(negedge clk);
        end
        // catch stray pulses after the last result
        repeat (3) @(negedge clk);
        assert_total = lsu_top_i.lsu_checker_i.assert_fails;
        $display("tests passed %0d, failed %0d, assertion failures %0d",
                 pass_count, fail_count, assert_total);
        if (fail_count == 0 && assert_total == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // run limit from table length, counted from reset release
    always @(negedge clk) begin
        if (!reset) begin
            cycles++;
            if (cycles > op_table.size() + 20) begin
                $display("timeout: only %0d of %0d tests finished after %0d cycles",
                         checked, op_table.size(), cycles);
                $display("ERRORS FOUND");
                $finish;
            end
        end
    end

endmodule

`default_nettype wire

/* sim.f */
rtl/lsu_pkg.sv
rtl/mem_req_stage.sv
rtl/data_mem.sv
rtl/load_align.sv
rtl/lsu_top.sv
verification/lsu_checker.sv
verification/lsu_scoreboard.sv
verification/tb_lsu.sv

/* Bender.yml */
package:
  name: lsu

sources:
  # design, package first
  - files:
      - rtl/lsu_pkg.sv
      - rtl/mem_req_stage.sv
      - rtl/data_mem.sv
      - rtl/load_align.sv
      - rtl/lsu_top.sv

  # testbench, checker and scoreboard
  - target: simulation
    files:
      - verification/lsu_checker.sv
      - verification/lsu_scoreboard.sv
      - verification/tb_lsu.sv
